/* Makefile */
TOP = tb_mem_pipe

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

/* build.f */
hw/mem_pipe_pkg.sv
hw/mem_agu.sv
hw/mem_dtlb.sv
hw/mem_dmem.sv
hw/mem_late_wb.sv
hw/mem_pipe.sv
verif/mem_pipe_properties.sv
verif/tb_mem_pipe.sv

/* hw/mem_agu.sv */
//////////////////////////////////////////////////
// Address generation for a dispatched load/store.
// Forms the effective address and decodes the op
// into size and class, flagging misalignment.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_agu
  import mem_pipe_pkg::*;
 (input  mem_dispatch_s dispatch_i
  , output mem_req_s    req_o
  , output logic        misaligned_o
  );

  logic [XLEN-1:0] sum;

  assign sum = dispatch_i.rs1 + dispatch_i.imm;

  always_comb
  begin
    req_o.op      = dispatch_i.op;
    req_o.rd      = dispatch_i.rd;
    req_o.eaddr   = sum[VADDR_W-1:0];
    req_o.is_load = dispatch_i.op inside {e_op_lb, e_op_lh, e_op_lw, e_op_ld,
                                          e_op_lbu, e_op_lhu, e_op_lwu,
                                          e_op_flw, e_op_fld};
    req_o.is_store = dispatch_i.op inside {e_op_sb, e_op_sh, e_op_sw, e_op_sd,
                                           e_op_fsw, e_op_fsd};
    req_o.is_float = dispatch_i.op inside {e_op_flw, e_op_fld, e_op_fsw, e_op_fsd};

    unique case (dispatch_i.op)
      e_op_lb, e_op_lbu, e_op_sb:                   req_o.size = 2'd0;
      e_op_lh, e_op_lhu, e_op_sh:                   req_o.size = 2'd1;
      e_op_lw, e_op_lwu, e_op_sw, e_op_flw, e_op_fsw: req_o.size = 2'd2;
      default:                                      req_o.size = 2'd3;
    endcase

    // Single-precision store keeps only the raw low word
    if (dispatch_i.op == e_op_fsw)
    begin
      req_o.st_data = {{(XLEN-32){1'b0}}, dispatch_i.rs2[31:0]};
    end
    else
    begin
      req_o.st_data = dispatch_i.rs2;
    end
  end

  always_comb
  begin
    unique case (req_o.size)
      2'd0:    misaligned_o = 1'b0;
      2'd1:    misaligned_o = req_o.eaddr[0];
      2'd2:    misaligned_o = |req_o.eaddr[1:0];
      default: misaligned_o = |req_o.eaddr[2:0];
    endcase
  end

endmodule

/* hw/mem_dmem.sv */
//////////////////////////////////////////////////
// Two-page tightly coupled data memory. Stores are
// byte masked; loads are read, shaped and then
// registered for the next stage.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_dmem
  import mem_pipe_pkg::*;
 (input                 clk_i
  , input               rst_n_i
  , input               v_i
  , input  mem_req_s    req_i
  , input  [PTAG_W-1:0] ptag_i
  , input               allow_i
  , output logic        load_v_o
  , output logic        load_float_o
  , output mem_wb_s     load_o
  );

  logic [XLEN-1:0]               mem [DMEM_WORDS];
  logic [$clog2(DMEM_WORDS)-1:0] idx;
  logic [2:0]                    ofs;
  logic [7:0]                    base_mask, byte_mask;
  logic [XLEN-1:0]               wdata, rword, shaped;
  logic                          store_en, load_en;

  // Double-word index is the low page bit above the page offset
  assign idx = {ptag_i[$clog2(DMEM_PAGES)-1:0], req_i.eaddr[PAGE_OFS_W-1:3]};
  assign ofs = req_i.eaddr[2:0];

  assign store_en = v_i && req_i.is_store && allow_i;
  assign load_en  = v_i && req_i.is_load && allow_i;

  always_comb
  begin
    unique case (req_i.size)
      2'd0:    base_mask = 8'h01;
      2'd1:    base_mask = 8'h03;
      2'd2:    base_mask = 8'h0f;
      default: base_mask = 8'hff;
    endcase
    byte_mask = base_mask << ofs;
    wdata = req_i.st_data << {ofs, 3'b000};
  end

  always_ff @(posedge clk_i)
  begin
    if (store_en)
    begin
      for (int b = 0; b < XLEN/8; b++)
      begin
        if (byte_mask[b])
        begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  assign rword = mem[idx] >> {ofs, 3'b000};

  always_comb
  begin
    unique case (req_i.op)
      e_op_lb:  shaped = {{(XLEN-8){rword[7]}}, rword[7:0]};
      e_op_lbu: shaped = {{(XLEN-8){1'b0}}, rword[7:0]};
      e_op_lh:  shaped = {{(XLEN-16){rword[15]}}, rword[15:0]};
      e_op_lhu: shaped = {{(XLEN-16){1'b0}}, rword[15:0]};
      e_op_lw:  shaped = {{(XLEN-32){rword[31]}}, rword[31:0]};
      e_op_lwu: shaped = {{(XLEN-32){1'b0}}, rword[31:0]};
      // NaN-box single precision
      e_op_flw: shaped = {{(XLEN-32){1'b1}}, rword[31:0]};
      default:  shaped = rword;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      load_v_o <= 1'b0;
    end
    else
    begin
      load_v_o <= load_en;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_en)
    begin
      load_float_o <= req_i.is_float;
      load_o.rd    <= req_i.rd;
      load_o.data  <= shaped;
    end
  end

endmodule

/* hw/mem_dtlb.sv */
//////////////////////////////////////////////////
// Four-entry fully associative data TLB. Filled
// round robin, flushed by sfence; the lookup and
// its fault flags are registered for stage 1.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_dtlb
  import mem_pipe_pkg::*;
 (input                       clk_i
  , input                     rst_n_i
  , input                     sfence_i
  , input                     trans_en_i
  , input                     fill_v_i
  , input  tlb_fill_s         fill_i
  , input                     lookup_v_i
  , input  [VTAG_W-1:0]       vtag_i
  , input                     is_load_i
  , input                     is_store_i
  , input                     misaligned_i
  , output logic [PTAG_W-1:0] ptag_o
  , output mem_excp_s         excp_o
  );

  logic [TLB_ENTRIES-1:0]         valid_r;
  logic [VTAG_W-1:0]              vtag_r [TLB_ENTRIES];
  pte_s                           pte_r  [TLB_ENTRIES];
  logic [$clog2(TLB_ENTRIES)-1:0] rr_r;
  logic [TLB_ENTRIES-1:0]         fill_hit, rr_onehot, fill_sel;
  logic                           hit, miss, readable, writable, out_of_range;
  pte_s                           hit_pte;
  logic [PTAG_W-1:0]              ptag;
  mem_excp_s                      excp;

  // A refill of a present tag replaces it in place
  always_comb
  begin
    rr_onehot = '0;
    rr_onehot[rr_r] = 1'b1;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      fill_hit[i] = valid_r[i] && (vtag_r[i] == fill_i.vtag);
    end
    fill_sel = (|fill_hit) ? fill_hit : rr_onehot;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i || sfence_i)
    begin
      valid_r <= '0;
    end
    else if (fill_v_i)
    begin
      valid_r <= valid_r | fill_sel;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rr_r <= '0;
    end
    else if (fill_v_i && !sfence_i && !(|fill_hit))
    begin
      rr_r <= rr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (fill_v_i && fill_sel[i])
      begin
        vtag_r[i] <= fill_i.vtag;
        pte_r[i]  <= fill_i.pte;
      end
    end
  end

  always_comb
  begin
    hit = 1'b0;
    hit_pte = '0;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (valid_r[i] && (vtag_r[i] == vtag_i))
      begin
        hit = 1'b1;
        hit_pte = pte_r[i];
      end
    end
    // Bare mode maps the page to itself with full permission
    miss     = trans_en_i && !hit;
    ptag     = trans_en_i ? hit_pte.ppn : vtag_i;
    readable = !trans_en_i || hit_pte.readable;
    writable = !trans_en_i || hit_pte.writable;
    out_of_range = ptag >= PTAG_W'(DMEM_PAGES);

    excp.tlb_load_miss      = is_load_i && miss;
    excp.tlb_store_miss     = is_store_i && miss;
    excp.load_misaligned    = is_load_i && misaligned_i;
    excp.store_misaligned   = is_store_i && misaligned_i;
    excp.load_page_fault    = is_load_i && !miss && !readable;
    excp.store_page_fault   = is_store_i && !miss && !writable;
    excp.load_access_fault  = is_load_i && !miss && out_of_range;
    excp.store_access_fault = is_store_i && !miss && out_of_range;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      excp_o <= '0;
    end
    else
    begin
      excp_o <= lookup_v_i ? excp : '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    ptag_o <= ptag;
  end

endmodule

/* hw/mem_late_wb.sv */
//////////////////////////////////////////////////
// One-entry buffer for float load results, taken
// with yumi. Also raises busy so that dispatch
// stops until the buffer can accept a result.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_late_wb
  import mem_pipe_pkg::*;
 (input               clk_i
  , input             rst_n_i
  , input             v_i
  , input  mem_wb_s   data_i
  , input  [1:0]      float_inflight_i
  , output logic      v_o
  , output mem_wb_s   data_o
  , input             yumi_i
  , output logic      busy_o
  );

  logic full_r;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_r <= 1'b0;
    end
    else
    begin
      full_r <= v_i || (full_r && !yumi_i);
    end
  end

  // Held until yumi, since busy keeps a new entry from arriving early
  always_ff @(posedge clk_i)
  begin
    if (v_i)
    begin
      data_o <= data_i;
    end
  end

  assign v_o    = full_r;
  assign busy_o = full_r || (float_inflight_i != 2'd0);

endmodule

/* hw/mem_pipe.sv */
//////////////////////////////////////////////////
// Data-memory pipeline top. One load or store per
// cycle in; integer loads out early, float loads
// out late through the yumi buffer.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_pipe
  import mem_pipe_pkg::*;
 (input                clk_i
  , input              rst_n_i
  , input              sfence_i
  , input              trans_en_i
  , input              dispatch_v_i
  , input  mem_dispatch_s dispatch_i
  , input              fill_v_i
  , input  tlb_fill_s  fill_i
  , output mem_excp_s  excp_o
  , output logic       early_v_o
  , output mem_wb_s    early_o
  , output logic       late_v_o
  , output mem_wb_s    late_o
  , input              late_yumi_i
  , output logic       busy_o
  );

  mem_req_s          req, s1_req_r;
  logic              misaligned, s1_v_r, allow;
  logic [PTAG_W-1:0] s1_ptag;
  logic              load_v, load_float, s1_float, s2_float;
  mem_wb_s           load_wb;
  logic [1:0]        float_inflight;

  mem_agu agu
   (.dispatch_i(dispatch_i)
    ,.req_o(req)
    ,.misaligned_o(misaligned)
    );

  mem_dtlb dtlb
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.sfence_i(sfence_i)
    ,.trans_en_i(trans_en_i)
    ,.fill_v_i(fill_v_i)
    ,.fill_i(fill_i)
    ,.lookup_v_i(dispatch_v_i)
    ,.vtag_i(req.eaddr[VADDR_W-1:PAGE_OFS_W])
    ,.is_load_i(req.is_load)
    ,.is_store_i(req.is_store)
    ,.misaligned_i(misaligned)
    ,.ptag_o(s1_ptag)
    ,.excp_o(excp_o)
    );

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      s1_v_r <= 1'b0;
    end
    else
    begin
      s1_v_r <= dispatch_v_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dispatch_v_i)
    begin
      s1_req_r <= req;
    end
  end

  // Any flag kills the memory access
  assign allow = ~(|excp_o);

  mem_dmem dmem
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(s1_v_r)
    ,.req_i(s1_req_r)
    ,.ptag_i(s1_ptag)
    ,.allow_i(allow)
    ,.load_v_o(load_v)
    ,.load_float_o(load_float)
    ,.load_o(load_wb)
    );

  assign early_v_o = load_v && !load_float;
  assign early_o   = load_wb;

  assign s1_float = s1_v_r && s1_req_r.is_load && s1_req_r.is_float;
  assign s2_float = load_v && load_float;
  assign float_inflight = {1'b0, s1_float} + {1'b0, s2_float};

  mem_late_wb late_wb
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.v_i(s2_float)
    ,.data_i(load_wb)
    ,.float_inflight_i(float_inflight)
    ,.v_o(late_v_o)
    ,.data_o(late_o)
    ,.yumi_i(late_yumi_i)
    ,.busy_o(busy_o)
    );

endmodule

/* hw/mem_pipe_pkg.sv */
//////////////////////////////////////////////////
// Widths, op codes and packet structs shared by
// the data-memory pipeline and its testbench.
// Modules take it by a wildcard import.
//////////////////////////////////////////////////

package mem_pipe_pkg;

  localparam int VADDR_W     = 32;
  localparam int PAGE_OFS_W  = 12;
  localparam int VTAG_W      = 20;
  localparam int PTAG_W      = 20;
  localparam int XLEN        = 64;
  localparam int REG_ADDR_W  = 5;
  localparam int TLB_ENTRIES = 4;
  // Physical pages backed by memory, higher pages raise an access fault
  localparam int DMEM_PAGES  = 2;
  localparam int DMEM_WORDS  = 1024;

  typedef enum logic [3:0] {
    e_op_lb  = 4'd0,
    e_op_lh  = 4'd1,
    e_op_lw  = 4'd2,
    e_op_ld  = 4'd3,
    e_op_lbu = 4'd4,
    e_op_lhu = 4'd5,
    e_op_lwu = 4'd6,
    e_op_sb  = 4'd7,
    e_op_sh  = 4'd8,
    e_op_sw  = 4'd9,
    e_op_sd  = 4'd10,
    e_op_flw = 4'd11,
    e_op_fld = 4'd12,
    e_op_fsw = 4'd13,
    e_op_fsd = 4'd14
  } mem_op_e;

  typedef struct packed {
    mem_op_e                op;
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        rs1;
    logic [XLEN-1:0]        rs2;
    logic [XLEN-1:0]        imm;
  } mem_dispatch_s;

  typedef struct packed {
    logic [PTAG_W-1:0]      ppn;
    logic                   readable;
    logic                   writable;
  } pte_s;

  typedef struct packed {
    logic [VTAG_W-1:0]      vtag;
    pte_s                   pte;
  } tlb_fill_s;

  typedef struct packed {
    logic                   tlb_load_miss;
    logic                   tlb_store_miss;
    logic                   load_misaligned;
    logic                   store_misaligned;
    logic                   load_page_fault;
    logic                   store_page_fault;
    logic                   load_access_fault;
    logic                   store_access_fault;
  } mem_excp_s;

  // Size is log2 of the access width in bytes
  typedef struct packed {
    mem_op_e                op;
    logic [REG_ADDR_W-1:0]  rd;
    logic [VADDR_W-1:0]     eaddr;
    logic [XLEN-1:0]        st_data;
    logic [1:0]             size;
    logic                   is_load;
    logic                   is_store;
    logic                   is_float;
  } mem_req_s;

  typedef struct packed {
    logic [REG_ADDR_W-1:0]  rd;
    logic [XLEN-1:0]        data;
  } mem_wb_s;

endpackage

/* verif/mem_pipe_properties.sv */
//////////////////////////////////////////////////
// Concurrent checks on the pipeline top, bound
// into every mem_pipe instance.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_pipe_properties
  import mem_pipe_pkg::*;
 (input               clk_i
  , input             rst_n_i
  , input             s1_v_r
  , input  mem_req_s  s1_req_r
  , input  mem_excp_s excp_o
  , input             early_v_o
  , input             late_v_o
  , input  mem_wb_s   late_o
  , input             late_yumi_i
  , input             busy_o
  );

  excp_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !s1_v_r |-> excp_o == '0)
    else $error("excp_o set with stage 1 empty");

  // Entry must hold until the consumer takes it
  late_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    late_v_o && !late_yumi_i |=> late_v_o && $stable(late_o))
    else $error("late_o changed before yumi");

  float_not_early: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s1_v_r && s1_req_r.is_load && s1_req_r.is_float |=> !early_v_o)
    else $error("float load result on the early port");

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> !early_v_o && !late_v_o && !busy_o && excp_o == '0)
    else $error("output active during reset");

endmodule

bind mem_pipe mem_pipe_properties props
 (.clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.s1_v_r(s1_v_r)
  ,.s1_req_r(s1_req_r)
  ,.excp_o(excp_o)
  ,.early_v_o(early_v_o)
  ,.late_v_o(late_v_o)
  ,.late_o(late_o)
  ,.late_yumi_i(late_yumi_i)
  ,.busy_o(busy_o)
  );

/* verif/tb_mem_pipe.sv */
//////////////////////////////////////////////////
// Random load/store testbench for mem_pipe. A
// reference model of TLB and memory predicts flags
// and results, checked every cycle after the edge.
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mem_pipe
  import mem_pipe_pkg::*;
 ();

  localparam int N_PRELOAD   = DMEM_PAGES * 32;
  localparam int N_BARE      = 300;
  localparam int N_TRANS     = 300;
  localparam int N_FENCE     = 16;
  localparam int CYCLE_LIMIT = 10 * (N_PRELOAD + N_BARE + N_TRANS + N_FENCE) + 200;

  logic          clk_i = 1'b0;
  logic          rst_n_i, sfence_i, trans_en_i, dispatch_v_i, fill_v_i, late_yumi_i;
  mem_dispatch_s dispatch_i;
  tlb_fill_s     fill_i;
  mem_excp_s     excp_o;
  logic          early_v_o, late_v_o, busy_o;
  mem_wb_s       early_o, late_o;

  logic [15:0]       lfsr = 16'd10;
  logic [XLEN-1:0]   ref_mem [DMEM_WORDS];
  logic              tlb_v   [TLB_ENTRIES];
  logic [VTAG_W-1:0] tlb_tag [TLB_ENTRIES];
  pte_s              tlb_pte [TLB_ENTRIES];
  int                tlb_next = 0;
  int                cyc = 0;
  int                errors = 0;
  // Expectations keyed by the cycle they are due in
  mem_excp_s         exp_excp [int];
  mem_wb_s           exp_early [int];
  bit                exp_s1_float [int];
  bit                exp_late_due [int];
  mem_wb_s           late_q [$];

  mem_pipe dut_i (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cyc <= cyc + 1;
  end

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic int size_bytes(input mem_op_e op);
    case (op)
      e_op_lb, e_op_lbu, e_op_sb:           return 1;
      e_op_lh, e_op_lhu, e_op_sh:           return 2;
      e_op_ld, e_op_sd, e_op_fld, e_op_fsd: return 8;
      default:                              return 4;
    endcase
  endfunction

  // Reference model: flags, memory update and shaped load data
  function automatic void predict(input mem_dispatch_s d, output mem_excp_s ex,
                                  output logic load_ok, output mem_wb_s wb);
    logic [VADDR_W-1:0] ea;
    logic [VTAG_W-1:0]  vpn;
    logic [PTAG_W-1:0]  ppn;
    logic               ld, st, hit, rd_ok, wr_ok, mis, oor;
    logic [XLEN-1:0]    raw;
    int                 nbytes, idx, ofs;
    ea = VADDR_W'(d.rs1 + d.imm);
    vpn = ea[VADDR_W-1:PAGE_OFS_W];
    ld = (d.op <= e_op_lwu) || (d.op inside {e_op_flw, e_op_fld});
    st = !ld;
    nbytes = size_bytes(d.op);
    ofs = int'(ea[2:0]);
    mis = (ofs % nbytes) != 0;
    hit = !trans_en_i;
    ppn = vpn;
    rd_ok = 1'b1;
    wr_ok = 1'b1;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (trans_en_i && tlb_v[i] && tlb_tag[i] == vpn)
      begin
        hit = 1'b1;
        ppn = tlb_pte[i].ppn;
        rd_ok = tlb_pte[i].readable;
        wr_ok = tlb_pte[i].writable;
      end
    end
    oor = int'(ppn) >= DMEM_PAGES;
    ex.tlb_load_miss      = ld && !hit;
    ex.tlb_store_miss     = st && !hit;
    ex.load_misaligned    = ld && mis;
    ex.store_misaligned   = st && mis;
    ex.load_page_fault    = ld && hit && !rd_ok;
    ex.store_page_fault   = st && hit && !wr_ok;
    ex.load_access_fault  = ld && hit && oor;
    ex.store_access_fault = st && hit && oor;
    load_ok = ld && (ex == '0);
    idx = int'(ppn[0]) * (DMEM_WORDS / DMEM_PAGES) + int'(ea[PAGE_OFS_W-1:3]);
    wb.rd = d.rd;
    wb.data = '0;
    if (st && ex == '0)
    begin
      for (int b = 0; b < nbytes; b++)
      begin
        ref_mem[idx][8 * (ofs + b) +: 8] = d.rs2[8 * b +: 8];
      end
    end
    if (load_ok)
    begin
      raw = ref_mem[idx] >> (8 * ofs);
      case (d.op)
        e_op_lb:  wb.data = XLEN'($signed(raw[7:0]));
        e_op_lh:  wb.data = XLEN'($signed(raw[15:0]));
        e_op_lw:  wb.data = XLEN'($signed(raw[31:0]));
        e_op_lbu: wb.data = XLEN'(raw[7:0]);
        e_op_lhu: wb.data = XLEN'(raw[15:0]);
        e_op_lwu: wb.data = XLEN'(raw[31:0]);
        e_op_flw: wb.data = {32'hffff_ffff, raw[31:0]};
        default:  wb.data = raw;
      endcase
    end
  endfunction

  function automatic mem_dispatch_s random_op(input logic translated);
    mem_dispatch_s         d;
    logic [2:0]            pick;
    logic [VTAG_W-1:0]     vpn;
    logic [PAGE_OFS_W-1:0] ofs;
    logic [XLEN-1:0]       imm;
    d.op = mem_op_e'(4'(take_bits(4) % 15));
    d.rd = REG_ADDR_W'(take_bits(REG_ADDR_W));
    pick = 3'(take_bits(3));
    // Pages 2 and up exist only to fault
    if (translated)
    begin
      vpn = VTAG_W'(8'h10 + (pick % 5));
    end
    else
    begin
      vpn = (pick < 6) ? VTAG_W'(pick[0]) : VTAG_W'(pick - 3'd4);
    end
    ofs = PAGE_OFS_W'(take_bits(8));
    if (take_bits(2) != 0)
    begin
      ofs = ofs & ~PAGE_OFS_W'(size_bytes(d.op) - 1);
    end
    imm = XLEN'($signed(6'(take_bits(6))));
    d.imm = imm;
    d.rs1 = {24'h0, 8'(take_bits(8)), vpn, ofs} - imm;
    d.rs2 = take_bits(XLEN);
    return d;
  endfunction

  task automatic fail_and_stop();
    errors++;
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_excp(input string name, input mem_excp_s got, input mem_excp_s want);
    if (got !== want)
    begin
      $display("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, want);
      fail_and_stop();
    end
  endtask

  task automatic check_wb(input string name, input mem_wb_s got, input mem_wb_s want);
    if (got !== want)
    begin
      $display("[FAIL] %s: got rd 0x%02h data 0x%016h, expected rd 0x%02h data 0x%016h",
               name, got.rd, got.data, want.rd, want.data);
      fail_and_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, want);
      fail_and_stop();
    end
  endtask

  // Next falling edge: clear strobes and give yumi at random
  task automatic tick();
    @(negedge clk_i);
    dispatch_v_i = 1'b0;
    fill_v_i = 1'b0;
    sfence_i = 1'b0;
    late_yumi_i = 1'b0;
    if (late_v_o && take_bits(1) == 64'd1)
    begin
      late_yumi_i = 1'b1;
      void'(late_q.pop_front());
    end
  endtask

  task automatic send(input mem_dispatch_s d);
    mem_excp_s ex;
    mem_wb_s   wb;
    logic      load_ok;
    tick();
    while (busy_o)
    begin
      tick();
    end
    predict(d, ex, load_ok, wb);
    dispatch_v_i = 1'b1;
    dispatch_i = d;
    exp_excp[cyc + 1] = ex;
    if (d.op inside {e_op_flw, e_op_fld})
    begin
      exp_s1_float[cyc + 1] = 1'b1;
      if (load_ok)
      begin
        late_q.push_back(wb);
        exp_late_due[cyc + 3] = 1'b1;
      end
    end
    else if (load_ok)
    begin
      exp_early[cyc + 2] = wb;
    end
  endtask

  task automatic issue_ops(input int n, input logic translated);
    for (int i = 0; i < n; i++)
    begin
      send(random_op(translated));
    end
  endtask

  task automatic fill_entry(input logic [VTAG_W-1:0] vtag, input logic [PTAG_W-1:0] ppn,
                            input logic r, input logic w);
    int slot;
    tick();
    fill_v_i = 1'b1;
    fill_i.vtag = vtag;
    fill_i.pte.ppn = ppn;
    fill_i.pte.readable = r;
    fill_i.pte.writable = w;
    slot = -1;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      if (tlb_v[i] && tlb_tag[i] == vtag)
      begin
        slot = i;
      end
    end
    // Round robin only for a new tag
    if (slot < 0)
    begin
      slot = tlb_next;
      tlb_next = (tlb_next + 1) % TLB_ENTRIES;
    end
    tlb_v[slot] = 1'b1;
    tlb_tag[slot] = vtag;
    tlb_pte[slot] = fill_i.pte;
  endtask

  task automatic flush_tlb();
    tick();
    sfence_i = 1'b1;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      tlb_v[i] = 1'b0;
    end
  endtask

  always
  begin : compare
    mem_excp_s want_excp;
    @(posedge clk_i);
    #1;
    if (rst_n_i)
    begin
      want_excp = '0;
      if (exp_excp.exists(cyc))
      begin
        want_excp = exp_excp[cyc];
      end
      check_excp("excp_o", excp_o, want_excp);
      check_flag("early_v_o", early_v_o, exp_early.exists(cyc) != 0);
      if (exp_early.exists(cyc))
      begin
        check_wb("early_o", early_o, exp_early[cyc]);
      end
      check_flag("busy_o", busy_o, exp_s1_float.exists(cyc) != 0 || late_q.size() != 0);
      if (exp_late_due.exists(cyc) && !late_v_o)
      begin
        $display("A float load result did not reach the late port in time");
        fail_and_stop();
      end
      if (late_v_o)
      begin
        if (late_q.size() == 0)
        begin
          $display("The late port raised a result with no float load outstanding");
          fail_and_stop();
        end
        else
        begin
          check_wb("late_o", late_o, late_q[0]);
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (cyc >= CYCLE_LIMIT)
    begin
      $display("The run timed out after %0d cycles", cyc);
      fail_and_stop();
    end
  end

  initial
  begin
    mem_dispatch_s d;
    logic [31:0]   addr;
    rst_n_i = 1'b0;
    sfence_i = 1'b0;
    trans_en_i = 1'b0;
    dispatch_v_i = 1'b0;
    dispatch_i = '0;
    fill_v_i = 1'b0;
    fill_i = '0;
    late_yumi_i = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++)
    begin
      tlb_v[i] = 1'b0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Pattern over the low 256 bytes of each backed page
    for (int p = 0; p < DMEM_PAGES; p++)
    begin
      for (int w = 0; w < 32; w++)
      begin
        addr = 32'(p * 4096 + w * 8);
        d.op = e_op_sd;
        d.rd = '0;
        d.rs1 = XLEN'(addr);
        d.imm = '0;
        d.rs2 = {~addr, addr};
        send(d);
      end
    end
    issue_ops(N_BARE, 1'b0);

    tick();
    trans_en_i = 1'b1;
    fill_entry(20'h10, 20'h0, 1'b1, 1'b1);
    fill_entry(20'h11, 20'h1, 1'b1, 1'b0);
    fill_entry(20'h12, 20'h2, 1'b1, 1'b1);
    fill_entry(20'h13, 20'h0, 1'b0, 1'b1);
    issue_ops(N_TRANS / 2, 1'b1);
    // Refill of a present tag, must not evict another page
    fill_entry(20'h11, 20'h1, 1'b1, 1'b1);
    issue_ops(N_TRANS / 2, 1'b1);

    flush_tlb();
    issue_ops(N_FENCE, 1'b1);

    repeat (4) tick();
    while (late_q.size() != 0)
    begin
      tick();
    end
    repeat (4) tick();

    if (errors == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule
